/* Bender.yml */
package:
  name: axi_wr_crossbar

sources:
  - source/axi_wr_pkg.sv
  - source/axi_wr_if.sv
  - source/grant_if.sv
  - source/region_decoder.sv
  - source/write_arbiter.sv
  - source/write_router.sv
  - source/axi_wr_crossbar.sv
  - target: test
    files:
      - verif/tb_axi_wr_crossbar.sv

/* sim.f */
source/axi_wr_pkg.sv
source/axi_wr_if.sv
source/grant_if.sv
source/region_decoder.sv
source/write_arbiter.sv
source/write_router.sv
source/axi_wr_crossbar.sv
verif/tb_axi_wr_crossbar.sv

/* source/axi_wr_crossbar.sv */
// Write path for 2 managers and 4 subordinates; a stalled UART write to SUB_NONE is never cleared
`timescale 1ns/1ps

module axi_wr_crossbar
    import axi_wr_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              processor_resetn,
    // UART bridge as manager 0
    input  logic [ADDR_W-1:0] uart_awaddr,
    input  logic [DATA_W-1:0] uart_wdata,
    input  logic [STRB_W-1:0] uart_wstrb,
    input  logic              uart_awvalid, uart_wvalid, uart_bready,
    output logic              uart_awready, uart_wready, uart_bvalid,
    output logic [RESP_W-1:0] uart_bresp,
    // Processor as manager 1
    input  logic [ADDR_W-1:0] pico_awaddr,
    input  logic [DATA_W-1:0] pico_wdata,
    input  logic [STRB_W-1:0] pico_wstrb,
    input  logic              pico_awvalid, pico_wvalid, pico_bready,
    output logic              pico_awready, pico_wready, pico_bvalid,
    output logic [RESP_W-1:0] pico_bresp,
    // Block RAM
    output logic [ADDR_W-1:0] bram_awaddr,
    output logic [DATA_W-1:0] bram_wdata,
    output logic [STRB_W-1:0] bram_wstrb,
    output logic              bram_awvalid, bram_wvalid, bram_bready,
    input  logic              bram_awready, bram_wready, bram_bvalid,
    input  logic [RESP_W-1:0] bram_bresp,
    // SDRAM
    output logic [ADDR_W-1:0] sdram_awaddr,
    output logic [DATA_W-1:0] sdram_wdata,
    output logic [STRB_W-1:0] sdram_wstrb,
    output logic              sdram_awvalid, sdram_wvalid, sdram_bready,
    input  logic              sdram_awready, sdram_wready, sdram_bvalid,
    input  logic [RESP_W-1:0] sdram_bresp,
    // LED register
    output logic [ADDR_W-1:0] led_awaddr,
    output logic [DATA_W-1:0] led_wdata,
    output logic [STRB_W-1:0] led_wstrb,
    output logic              led_awvalid, led_wvalid, led_bready,
    input  logic              led_awready, led_wready, led_bvalid,
    input  logic [RESP_W-1:0] led_bresp,
    // Reset register
    output logic [ADDR_W-1:0] rst_reg_awaddr,
    output logic [DATA_W-1:0] rst_reg_wdata,
    output logic [STRB_W-1:0] rst_reg_wstrb,
    output logic              rst_reg_awvalid, rst_reg_wvalid, rst_reg_bready,
    input  logic              rst_reg_awready, rst_reg_wready, rst_reg_bvalid,
    input  logic [RESP_W-1:0] rst_reg_bresp
);

    decode_t uart_decoded;
    decode_t pico_decoded;

    axi_wr_if uart_if ();
    axi_wr_if pico_if ();
    axi_wr_if sub_if [NUM_SUBS] ();
    grant_if  g_if (.clk(clk));

    // ------------------------------------------------------------------
    // Manager ports
    // ------------------------------------------------------------------
    assign uart_if.awaddr  = uart_awaddr;
    assign uart_if.awvalid = uart_awvalid;
    assign uart_if.wdata   = uart_wdata;
    assign uart_if.wstrb   = uart_wstrb;
    assign uart_if.wvalid  = uart_wvalid;
    assign uart_if.bready  = uart_bready;
    assign uart_awready    = uart_if.awready;
    assign uart_wready     = uart_if.wready;
    assign uart_bresp      = uart_if.bresp;
    assign uart_bvalid     = uart_if.bvalid;

    assign pico_if.awaddr  = pico_awaddr;
    assign pico_if.awvalid = pico_awvalid;
    assign pico_if.wdata   = pico_wdata;
    assign pico_if.wstrb   = pico_wstrb;
    assign pico_if.wvalid  = pico_wvalid;
    assign pico_if.bready  = pico_bready;
    assign pico_awready    = pico_if.awready;
    assign pico_wready     = pico_if.wready;
    assign pico_bresp      = pico_if.bresp;
    assign pico_bvalid     = pico_if.bvalid;

    // ------------------------------------------------------------------
    // Subordinate ports in sub_e order
    // ------------------------------------------------------------------
    assign bram_awaddr          = sub_if[0].awaddr;
    assign bram_awvalid         = sub_if[0].awvalid;
    assign bram_wdata           = sub_if[0].wdata;
    assign bram_wstrb           = sub_if[0].wstrb;
    assign bram_wvalid          = sub_if[0].wvalid;
    assign bram_bready          = sub_if[0].bready;
    assign sub_if[0].awready    = bram_awready;
    assign sub_if[0].wready     = bram_wready;
    assign sub_if[0].bresp      = bram_bresp;
    assign sub_if[0].bvalid     = bram_bvalid;

    assign sdram_awaddr         = sub_if[1].awaddr;
    assign sdram_awvalid        = sub_if[1].awvalid;
    assign sdram_wdata          = sub_if[1].wdata;
    assign sdram_wstrb          = sub_if[1].wstrb;
    assign sdram_wvalid         = sub_if[1].wvalid;
    assign sdram_bready         = sub_if[1].bready;
    assign sub_if[1].awready    = sdram_awready;
    assign sub_if[1].wready     = sdram_wready;
    assign sub_if[1].bresp      = sdram_bresp;
    assign sub_if[1].bvalid     = sdram_bvalid;

    assign led_awaddr           = sub_if[2].awaddr;
    assign led_awvalid          = sub_if[2].awvalid;
    assign led_wdata            = sub_if[2].wdata;
    assign led_wstrb            = sub_if[2].wstrb;
    assign led_wvalid           = sub_if[2].wvalid;
    assign led_bready           = sub_if[2].bready;
    assign sub_if[2].awready    = led_awready;
    assign sub_if[2].wready     = led_wready;
    assign sub_if[2].bresp      = led_bresp;
    assign sub_if[2].bvalid     = led_bvalid;

    assign rst_reg_awaddr       = sub_if[3].awaddr;
    assign rst_reg_awvalid      = sub_if[3].awvalid;
    assign rst_reg_wdata        = sub_if[3].wdata;
    assign rst_reg_wstrb        = sub_if[3].wstrb;
    assign rst_reg_wvalid       = sub_if[3].wvalid;
    assign rst_reg_bready       = sub_if[3].bready;
    assign sub_if[3].awready    = rst_reg_awready;
    assign sub_if[3].wready     = rst_reg_wready;
    assign sub_if[3].bresp      = rst_reg_bresp;
    assign sub_if[3].bvalid     = rst_reg_bvalid;

    // ------------------------------------------------------------------
    // Decode, arbitration and routing
    // ------------------------------------------------------------------
    region_decoder #(.allow_rst_reg(1'b1)) u_uart_decoder (
        .awaddr  (uart_if.awaddr),
        .decoded (uart_decoded)
    );

    // Processor is kept away from the reset register
    region_decoder #(.allow_rst_reg(1'b0)) u_pico_decoder (
        .awaddr  (pico_if.awaddr),
        .decoded (pico_decoded)
    );

    write_arbiter u_arbiter (
        .clk              (clk),
        .resetn           (resetn),
        .processor_resetn (processor_resetn),
        .uart_awvalid     (uart_awvalid),
        .pico_awvalid     (pico_awvalid),
        .uart_decoded     (uart_decoded),
        .pico_decoded     (pico_decoded),
        .grant            (g_if.arb)
    );

    write_router u_router (
        .grant     (g_if.route),
        .uart_port (uart_if.sub),
        .pico_port (pico_if.sub),
        .subs      (sub_if)
    );

endmodule

/* source/axi_wr_if.sv */
// AXI-Lite write channels only (AW, W, B); no awprot and no read side
`timescale 1ns/1ps

interface axi_wr_if
    import axi_wr_pkg::*;
();

    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    logic [RESP_W-1:0] bresp;
    logic              bvalid;
    logic              bready;

    modport mgr (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );

    modport sub (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

/* source/axi_wr_pkg.sv */
// Shared widths, region map and decode types; region codes assume a 24-bit offset space per target
package axi_wr_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int RESP_W   = 2;
    localparam int REGION_W = 8;
    localparam int OFFSET_W = ADDR_W - REGION_W;
    localparam int NUM_SUBS = 4;

    // Top address byte of each mapped region
    localparam logic [REGION_W-1:0] BRAM_REGION    = 8'h00;
    localparam logic [REGION_W-1:0] SDRAM_REGION   = 8'h20;
    localparam logic [REGION_W-1:0] LED_REGION     = 8'h40;
    localparam logic [REGION_W-1:0] RST_REG_REGION = 8'h41;

    // First four values index the subordinate port array
    typedef enum logic [2:0] {
        SUB_BRAM    = 3'd0,
        SUB_SDRAM   = 3'd1,
        SUB_LED     = 3'd2,
        SUB_RST_REG = 3'd3,
        SUB_NONE    = 3'd4
    } sub_e;

    // Region byte is dropped, so the offset is the address with its top byte cleared
    typedef struct packed {
        sub_e                sub;
        logic [OFFSET_W-1:0] offset;
    } decode_t;

endpackage

/* source/grant_if.sv */
// Grant state of the single write path; clk is carried for checks in the routing logic only
`timescale 1ns/1ps

interface grant_if
    import axi_wr_pkg::*;
(
    input logic clk
);

    logic                active;
    logic                owner;     // 0 = UART, 1 = processor
    sub_e                sub;
    logic [OFFSET_W-1:0] offset;
    logic                done;

    modport arb (output active, owner, sub, offset, input done);

    modport route (input clk, active, owner, sub, offset, output done);

endinterface

/* source/region_decoder.sv */
// Pure address decode; unmapped regions and a blocked reset register both return SUB_NONE
`timescale 1ns/1ps

module region_decoder
    import axi_wr_pkg::*;
#(
    parameter bit allow_rst_reg = 1'b1
) (
    input  logic [ADDR_W-1:0] awaddr,
    output decode_t           decoded
);

    logic [REGION_W-1:0] region;

    assign region = awaddr[ADDR_W-1 -: REGION_W];

    always_comb begin
        decoded.offset = awaddr[OFFSET_W-1:0];
        case (region)
            BRAM_REGION: begin
                decoded.sub = SUB_BRAM;
            end
            SDRAM_REGION: begin
                decoded.sub = SUB_SDRAM;
            end
            LED_REGION: begin
                decoded.sub = SUB_LED;
            end
            RST_REG_REGION: begin
                // Only a privileged manager may hit the reset register
                decoded.sub = allow_rst_reg ? SUB_RST_REG : SUB_NONE;
            end
            default: begin
                decoded.sub = SUB_NONE;
            end
        endcase
    end

endmodule

/* source/write_arbiter.sv */
// One write in flight; UART has fixed priority and only a processor-owned write can be flushed
`timescale 1ns/1ps

module write_arbiter
    import axi_wr_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    processor_resetn,
    input  logic    uart_awvalid,
    input  logic    pico_awvalid,
    input  decode_t uart_decoded,
    input  decode_t pico_decoded,
    grant_if.arb    grant
);

    logic    flush;
    logic    start;
    decode_t win;

    assign flush = !processor_resetn && grant.owner;
    assign start = !grant.active && !flush && (uart_awvalid || pico_awvalid);
    assign win   = uart_awvalid ? uart_decoded : pico_decoded;

    // ------------------------------------------------------------------
    // Grant and ownership
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            grant.active <= 1'b0;
            grant.owner  <= 1'b0;
            grant.sub    <= SUB_NONE;
        end else if (flush) begin
            // Processor went into reset while holding the path
            grant.active <= 1'b0;
            grant.owner  <= 1'b0;
        end else if (start) begin
            grant.active <= 1'b1;
            grant.owner  <= !uart_awvalid;
            grant.sub    <= win.sub;
        end else if (grant.done) begin
            grant.active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            grant.offset <= win.offset;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_grant_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        grant.active |=> !grant.active || ($stable(grant.owner) && $stable(grant.sub))
    );

    // Completion from the router only while a write is granted
    a_done_needs_grant: assert property (
        @(posedge clk) disable iff (!resetn)
        !grant.active |-> !grant.done
    );

endmodule

/* source/write_router.sv */
// Combinational steering only; a SUB_NONE grant leaves the owner waiting with no readies
`timescale 1ns/1ps

module write_router
    import axi_wr_pkg::*;
(
    grant_if.route grant,
    axi_wr_if.sub  uart_port,
    axi_wr_if.sub  pico_port,
    axi_wr_if.mgr  subs [NUM_SUBS]
);

    logic                own_uart;
    logic                own_pico;
    logic                m_awvalid;
    logic [DATA_W-1:0]   m_wdata;
    logic [STRB_W-1:0]   m_wstrb;
    logic                m_wvalid;
    logic                m_bready;
    logic [NUM_SUBS-1:0] hit;
    logic [NUM_SUBS-1:0] s_awvalid;
    logic [NUM_SUBS-1:0] s_awready;
    logic [NUM_SUBS-1:0] s_wready;
    logic [NUM_SUBS-1:0] s_bvalid;
    logic [RESP_W-1:0]   s_bresp [NUM_SUBS];
    logic                sel_awready;
    logic                sel_wready;
    logic                sel_bvalid;
    logic [RESP_W-1:0]   sel_bresp;

    assign own_uart = grant.active && !grant.owner;
    assign own_pico = grant.active && grant.owner;

    // Owner side of the path
    assign m_awvalid = grant.owner ? pico_port.awvalid : uart_port.awvalid;
    assign m_wdata   = grant.owner ? pico_port.wdata   : uart_port.wdata;
    assign m_wstrb   = grant.owner ? pico_port.wstrb   : uart_port.wstrb;
    assign m_wvalid  = grant.owner ? pico_port.wvalid  : uart_port.wvalid;
    assign m_bready  = grant.owner ? pico_port.bready  : uart_port.bready;

    // ------------------------------------------------------------------
    // Subordinate side
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_SUBS; i++) begin : g_sub
        assign hit[i]          = grant.active && (grant.sub == sub_e'(i));
        assign s_awvalid[i]    = hit[i] && m_awvalid;
        assign subs[i].awaddr  = {{REGION_W{1'b0}}, grant.offset};
        assign subs[i].awvalid = s_awvalid[i];
        assign subs[i].wdata   = m_wdata;
        assign subs[i].wstrb   = m_wstrb;
        assign subs[i].wvalid  = hit[i] && m_wvalid;
        assign subs[i].bready  = hit[i] && m_bready;
        assign s_awready[i]    = subs[i].awready;
        assign s_wready[i]     = subs[i].wready;
        assign s_bvalid[i]     = subs[i].bvalid;
        assign s_bresp[i]      = subs[i].bresp;
    end

    assign sel_awready = |(hit & s_awready);
    assign sel_wready  = |(hit & s_wready);
    assign sel_bvalid  = |(hit & s_bvalid);

    always_comb begin
        sel_bresp = '0;
        for (int i = 0; i < NUM_SUBS; i++) begin
            if (hit[i]) begin
                sel_bresp = s_bresp[i];
            end
        end
    end

    // Back to the managers, non-owner sees nothing
    assign uart_port.awready = own_uart && sel_awready;
    assign uart_port.wready  = own_uart && sel_wready;
    assign uart_port.bvalid  = own_uart && sel_bvalid;
    assign uart_port.bresp   = own_uart ? sel_bresp : '0;

    assign pico_port.awready = own_pico && sel_awready;
    assign pico_port.wready  = own_pico && sel_wready;
    assign pico_port.bvalid  = own_pico && sel_bvalid;
    assign pico_port.bresp   = own_pico ? sel_bresp : '0;

    assign grant.done = sel_bvalid && m_bready;

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_single_target: assert property (
        @(posedge grant.clk) $onehot0(s_awvalid)
    );

    a_resp_to_owner: assert property (
        @(posedge grant.clk)
        (uart_port.bvalid |-> grant.active && !grant.owner) and
        (pico_port.bvalid |-> grant.active && grant.owner)
    );

endmodule

/* verif/tb_axi_wr_crossbar.sv */
// Reads verif/write_vectors.txt from the project root; expected subordinate 4 is valid for the processor only
`timescale 1ns/1ps

module tb_axi_wr_crossbar
    import axi_wr_pkg::*;
();

    logic clk;
    logic resetn;
    logic processor_resetn;

    // Manager side, index 0 is the UART and 1 the processor
    logic [1:0][ADDR_W-1:0] m_awaddr;
    logic [1:0][DATA_W-1:0] m_wdata;
    logic [1:0][STRB_W-1:0] m_wstrb;
    logic [1:0]             m_awvalid;
    logic [1:0]             m_wvalid;
    logic [1:0]             m_bready;
    logic [1:0]             m_awready;
    logic [1:0]             m_wready;
    logic [1:0]             m_bvalid;
    logic [1:0][RESP_W-1:0] m_bresp;

    // Subordinate side, indexed as sub_e
    logic [NUM_SUBS-1:0][ADDR_W-1:0] s_awaddr;
    logic [NUM_SUBS-1:0][DATA_W-1:0] s_wdata;
    logic [NUM_SUBS-1:0][STRB_W-1:0] s_wstrb;
    logic [NUM_SUBS-1:0]             s_awvalid;
    logic [NUM_SUBS-1:0]             s_wvalid;
    logic [NUM_SUBS-1:0]             s_bready;
    logic [NUM_SUBS-1:0]             s_awready = '0;
    logic [NUM_SUBS-1:0]             s_wready = '0;
    logic [NUM_SUBS-1:0]             s_bvalid = '0;
    logic [NUM_SUBS-1:0][RESP_W-1:0] s_bresp = '0;

    // Subordinate model state and captured writes {sub, awaddr, wdata, wstrb}
    logic [NUM_SUBS-1:0]             got_aw = '0;
    logic [NUM_SUBS-1:0]             got_w = '0;
    logic [NUM_SUBS-1:0][ADDR_W-1:0] cap_addr;
    logic [NUM_SUBS-1:0][DATA_W-1:0] cap_data;
    logic [NUM_SUBS-1:0][STRB_W-1:0] cap_strb;
    logic [70:0]                     cap_q [$];

    // Ready gates: [3:0] awready, [7:4] wready, [9:8] manager bready
    logic [9:0]  gate = '0;
    logic [31:0] lfsr = 32'h6daa_f483;

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int n_vec = 0;

    logic [31:0] v_mgr [$];
    logic [31:0] v_addr [$];
    logic [31:0] v_data [$];
    logic [31:0] v_strb [$];
    logic [31:0] v_both [$];
    logic [31:0] v_exp [$];

    axi_wr_crossbar DUT (
        .clk (clk), .resetn (resetn), .processor_resetn (processor_resetn),
        .uart_awaddr (m_awaddr[0]), .uart_wdata (m_wdata[0]), .uart_wstrb (m_wstrb[0]),
        .uart_awvalid (m_awvalid[0]), .uart_wvalid (m_wvalid[0]), .uart_bready (m_bready[0]),
        .uart_awready (m_awready[0]), .uart_wready (m_wready[0]), .uart_bvalid (m_bvalid[0]),
        .uart_bresp (m_bresp[0]),
        .pico_awaddr (m_awaddr[1]), .pico_wdata (m_wdata[1]), .pico_wstrb (m_wstrb[1]),
        .pico_awvalid (m_awvalid[1]), .pico_wvalid (m_wvalid[1]), .pico_bready (m_bready[1]),
        .pico_awready (m_awready[1]), .pico_wready (m_wready[1]), .pico_bvalid (m_bvalid[1]),
        .pico_bresp (m_bresp[1]),
        .bram_awaddr (s_awaddr[0]), .bram_wdata (s_wdata[0]), .bram_wstrb (s_wstrb[0]),
        .bram_awvalid (s_awvalid[0]), .bram_wvalid (s_wvalid[0]), .bram_bready (s_bready[0]),
        .bram_awready (s_awready[0]), .bram_wready (s_wready[0]), .bram_bvalid (s_bvalid[0]),
        .bram_bresp (s_bresp[0]),
        .sdram_awaddr (s_awaddr[1]), .sdram_wdata (s_wdata[1]), .sdram_wstrb (s_wstrb[1]),
        .sdram_awvalid (s_awvalid[1]), .sdram_wvalid (s_wvalid[1]), .sdram_bready (s_bready[1]),
        .sdram_awready (s_awready[1]), .sdram_wready (s_wready[1]), .sdram_bvalid (s_bvalid[1]),
        .sdram_bresp (s_bresp[1]),
        .led_awaddr (s_awaddr[2]), .led_wdata (s_wdata[2]), .led_wstrb (s_wstrb[2]),
        .led_awvalid (s_awvalid[2]), .led_wvalid (s_wvalid[2]), .led_bready (s_bready[2]),
        .led_awready (s_awready[2]), .led_wready (s_wready[2]), .led_bvalid (s_bvalid[2]),
        .led_bresp (s_bresp[2]),
        .rst_reg_awaddr (s_awaddr[3]), .rst_reg_wdata (s_wdata[3]), .rst_reg_wstrb (s_wstrb[3]),
        .rst_reg_awvalid (s_awvalid[3]), .rst_reg_wvalid (s_wvalid[3]),
        .rst_reg_bready (s_bready[3]), .rst_reg_awready (s_awready[3]),
        .rst_reg_wready (s_wready[3]), .rst_reg_bvalid (s_bvalid[3]), .rst_reg_bresp (s_bresp[3])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        galois_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always @(posedge clk) begin : gen_ready
        logic [9:0] g;
        for (int j = 0; j < 10; j++) begin
            g[j] = lfsr[0];
            lfsr = galois_step(lfsr);
        end
        gate <= g;
    end

    // ------------------------------------------------------------------
    // Subordinate models, response code equals the subordinate index
    // ------------------------------------------------------------------
    always @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s_awready <= '0;
            s_wready  <= '0;
            s_bvalid  <= '0;
            s_bresp   <= '0;
            got_aw    <= '0;
            got_w     <= '0;
        end else begin
            for (int i = 0; i < NUM_SUBS; i++) begin
                if (s_awvalid[i] && s_awready[i]) begin
                    got_aw[i]    <= 1'b1;
                    s_awready[i] <= 1'b0;
                    cap_addr[i]  <= s_awaddr[i];
                end else begin
                    s_awready[i] <= !got_aw[i] && gate[i];
                end
                if (s_wvalid[i] && s_wready[i]) begin
                    got_w[i]    <= 1'b1;
                    s_wready[i] <= 1'b0;
                    cap_data[i] <= s_wdata[i];
                    cap_strb[i] <= s_wstrb[i];
                end else begin
                    s_wready[i] <= !got_w[i] && gate[4 + i];
                end
                if (got_aw[i] && got_w[i] && !s_bvalid[i]) begin
                    s_bvalid[i] <= 1'b1;
                    s_bresp[i]  <= RESP_W'(i);
                    cap_q.push_back({3'(i), cap_addr[i], cap_data[i], cap_strb[i]});
                end else if (s_bvalid[i] && s_bready[i]) begin
                    s_bvalid[i] <= 1'b0;
                    got_aw[i]   <= 1'b0;
                    got_w[i]    <= 1'b0;
                end
            end
        end
    end

    task automatic compare(input string what, input logic [70:0] got, input logic [70:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: at %0d ns, %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (resetn) begin
            compare("subordinates with awvalid at most one", $countones(s_awvalid) <= 1, 1'b1);
        end
    end

    task automatic expect_capture(
        input int                sub,
        input logic [ADDR_W-1:0] offset,
        input logic [DATA_W-1:0] data,
        input logic [STRB_W-1:0] strb
    );
        logic [70:0] rec;
        if (cap_q.size() == 0) begin
            errors++;
            $display("Error: at %0d ns, no write reached any subordinate", $time);
        end else begin
            rec = cap_q.pop_front();
            compare("subordinate index", rec[70:68], sub);
            compare("subordinate awaddr", rec[67:36], offset);
            compare("subordinate wdata", rec[35:4], data);
            compare("subordinate wstrb", rec[3:0], strb);
        end
    endtask

    // ------------------------------------------------------------------
    // Manager driver, AW and W run independently, then B
    // ------------------------------------------------------------------
    task automatic drive_write(
        input  int                m,
        input  logic [ADDR_W-1:0] addr,
        input  logic [DATA_W-1:0] data,
        input  logic [STRB_W-1:0] strb,
        output logic [RESP_W-1:0] resp,
        output int                aw_cyc,
        output int                b_cyc
    );
        logic done;
        @(posedge clk);
        m_awaddr[m]  <= addr;
        m_awvalid[m] <= 1'b1;
        m_wdata[m]   <= data;
        m_wstrb[m]   <= strb;
        m_wvalid[m]  <= 1'b1;
        fork
            begin
                @(negedge clk);
                while (!m_awready[m]) @(negedge clk);
                aw_cyc = cycle;
                @(posedge clk);
                m_awvalid[m] <= 1'b0;
            end
            begin
                @(negedge clk);
                while (!m_wready[m]) @(negedge clk);
                @(posedge clk);
                m_wvalid[m] <= 1'b0;
            end
        join
        done = 1'b0;
        while (!done) begin
            m_bready[m] <= gate[8 + m];
            @(negedge clk);
            done = m_bvalid[m] && m_bready[m];
            if (!done) @(posedge clk);
        end
        resp  = m_bresp[m];
        b_cyc = cycle;
        @(posedge clk);
        m_bready[m] <= 1'b0;
    endtask

    task automatic stall_and_recover(
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data,
        input logic [STRB_W-1:0] strb
    );
        logic seen_aw;
        logic seen_b;
        seen_aw = 1'b0;
        seen_b  = 1'b0;
        @(posedge clk);
        m_awaddr[1]  <= addr;
        m_awvalid[1] <= 1'b1;
        m_wdata[1]   <= data;
        m_wstrb[1]   <= strb;
        m_wvalid[1]  <= 1'b1;
        m_bready[1]  <= 1'b1;
        repeat (50) begin
            @(negedge clk);
            seen_aw = seen_aw || (s_awvalid != '0);
            seen_b  = seen_b || m_bvalid[1];
        end
        compare("subordinate awvalid during stall", seen_aw, 1'b0);
        compare("processor bvalid during stall", seen_b, 1'b0);
        // One cycle of processor reset, the processor drops its request with it
        @(posedge clk);
        processor_resetn <= 1'b0;
        m_awvalid[1]     <= 1'b0;
        m_wvalid[1]      <= 1'b0;
        m_bready[1]      <= 1'b0;
        @(posedge clk);
        processor_resetn <= 1'b1;
    endtask

    task automatic run_vector(input int k);
        logic [ADDR_W-1:0] offset;
        logic [DATA_W-1:0] u_data;
        logic [DATA_W-1:0] p_data;
        logic [RESP_W-1:0] u_resp;
        logic [RESP_W-1:0] p_resp;
        int                u_aw;
        int                u_b;
        int                p_aw;
        int                p_b;
        int                err0;
        string             kind;
        err0   = errors;
        offset = {{REGION_W{1'b0}}, v_addr[k][OFFSET_W-1:0]};
        if (v_exp[k] == 4 && v_mgr[k] == 1) begin
            kind = "stall and recovery";
            stall_and_recover(v_addr[k], v_data[k], v_strb[k]);
        end else if (v_exp[k] == 4) begin
            kind = "unsupported";
            errors++;
            $display("Vector %0d asks for a UART write that can never complete", k);
        end else if (v_both[k] != 0) begin
            kind = "simultaneous";
            // Other manager writes the same location with inverted data
            u_data = (v_mgr[k] == 0) ? v_data[k] : ~v_data[k];
            p_data = ~u_data;
            fork
                drive_write(0, v_addr[k], u_data, v_strb[k], u_resp, u_aw, u_b);
                drive_write(1, v_addr[k], p_data, v_strb[k], p_resp, p_aw, p_b);
            join
            compare("UART bresp", u_resp, v_exp[k]);
            compare("processor bresp", p_resp, v_exp[k]);
            compare("processor AW after UART B", p_aw > u_b, 1'b1);
            expect_capture(v_exp[k], offset, u_data, v_strb[k]);
            expect_capture(v_exp[k], offset, p_data, v_strb[k]);
        end else begin
            kind = (v_mgr[k] == 0) ? "UART routing" : "processor routing";
            drive_write(v_mgr[k], v_addr[k], v_data[k], v_strb[k], u_resp, u_aw, u_b);
            compare("bresp", u_resp, v_exp[k]);
            expect_capture(v_exp[k], offset, v_data[k], v_strb[k]);
        end
        repeat (2) @(posedge clk);
        $display("vector %0d, %s to %h: %s", k, kind, v_addr[k],
                 (errors == err0) ? "ok" : "mismatch");
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [31:0]      mgr;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      strb;
        logic [31:0]      both;
        logic [31:0]      exp;
        fd = $fopen("verif/write_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/write_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h", mgr, addr, data, strb, both, exp);
                if (n == 6) begin
                    v_mgr.push_back(mgr);
                    v_addr.push_back(addr);
                    v_data.push_back(data);
                    v_strb.push_back(strb);
                    v_both.push_back(both);
                    v_exp.push_back(exp);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        resetn           = 1'b0;
        processor_resetn = 1'b1;
        m_awaddr         = '0;
        m_wdata          = '0;
        m_wstrb          = '0;
        m_awvalid        = '0;
        m_wvalid         = '0;
        m_bready         = '0;
        load_vectors();
        if (v_addr.size() == 0) begin
            errors++;
            $display("No vectors were read, nothing was tested");
        end else begin
            n_vec = v_addr.size();
            repeat (4) @(posedge clk);
            resetn <= 1'b1;
            repeat (2) @(posedge clk);
            for (int k = 0; k < n_vec; k++) begin
                run_vector(k);
            end
        end
        if (cap_q.size() != 0) begin
            errors++;
            $display("%0d writes reached a subordinate without a matching test", cap_q.size());
        end
        $display("%0d vectors, %0d checks, %0d errors", n_vec, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 200) @(posedge clk);
        $display("Timeout: the vectors did not finish within %0d cycles", n_vec * 200);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verif/write_vectors.txt */
// manager address data strobe simultaneous expected_sub (all hex)
// manager 0 = UART, 1 = processor; expected_sub 4 = none, processor only
0 00001000 11111111 f 0 0
0 20000404 22222222 3 0 1
0 40000008 33333333 1 0 2
0 41000000 44444444 f 0 3
1 00abcdef 55555555 f 0 0
1 20123450 66666666 c 0 1
1 40000010 77777777 f 0 2
1 41000000 88888888 f 0 4
0 00000020 99999999 f 0 0
1 7f000000 aaaaaaaa f 0 4
0 40000000 bbbbbbbb 8 0 2
0 20000100 cccccccc f 1 1
1 00000200 dddddddd f 1 0
0 40000004 eeeeeeee 6 1 2
1 2000fff0 0badf00d f 0 1
0 41000010 5a5a5a5a a 0 3
1 40000020 12345678 f 0 2
0 00fffffc 87654321 f 0 0
